//--- hw/cache_pkg.sv
package cache_pkg;

    // host side
    localparam int word_w = 32;  // one host word
    localparam int addr_w = 32;  // byte address, host and pmem

    // line geometry
    localparam int line_words = 8;  // words per line
    localparam int offset_w   = 5;  // byte offset bits inside a line

    // single host word, read data and write data
    typedef logic [word_w-1:0] word_t;

    // one cache line
    // flat view is what crosses the pmem bus,
    // word view is used for host word select and write merge
    typedef union packed {
        logic [line_words*word_w-1:0] flat;   // whole line, pmem transfers
        word_t [line_words-1:0]       words;  // words[0] at lowest address
    } line_t;

    // address split, for sets = 2**idx_w
    //   [addr_w-1 : offset_w+idx_w]   tag
    //   [offset_w+idx_w-1 : offset_w] set index
    //   [offset_w-1 : 2]              word in line
    //   [1:0]                         byte in word, ignored
    // idx_w and the tag width depend on the set count and are
    // derived where the set count is known

endpackage

//--- hw/icache_control.sv
`timescale 1ns/1ns

module icache_control (
    input  logic clk,
    input  logic arst_n,
    // host request
    input  logic mem_read,
    input  logic mem_write,
    output logic mem_resp,
    // physical memory
    output logic pmem_read,
    output logic pmem_write,
    input  logic pmem_resp,
    // datapath status
    input  logic hit,            // tag match in some way
    input  logic valid,          // matching way is valid
    input  logic dirty,          // lru victim is dirty
    // datapath control
    output logic way_sel_method, // 0 hit way, 1 lru victim
    output logic load_line_data,
    output logic load_valid,
    output logic load_dirty,
    output logic load_lru,
    output logic line_datain_sel, // 0 pmem line, 1 merged host word
    output logic valid_in,
    output logic dirty_in,
    output logic address_sel,     // 0 request line, 1 victim line
    // miss traffic flag
    output logic if_miss
);

    typedef enum logic [1:0] {
        ready,
        write_back,
        read_mem
    } state_t;

    state_t state, next_state;

    logic req;     // host has a request up
    logic hit_ok;  // usable hit

    assign req    = mem_read || mem_write;
    assign hit_ok = hit && valid;

    // outputs per state
    always_comb begin
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        way_sel_method  = 1'b0;
        load_line_data  = 1'b0;
        load_valid      = 1'b0;
        load_dirty      = 1'b0;
        load_lru        = 1'b0;
        line_datain_sel = 1'b0;
        valid_in        = 1'b0;
        dirty_in        = 1'b0;
        address_sel     = 1'b0;
        if_miss         = 1'b0;

        case (state)
            ready: begin
                // hit answered this cycle, arrays update at the edge
                mem_resp        = hit_ok && req;
                load_lru        = hit_ok && req;
                load_line_data  = hit_ok && mem_write; // word merge
                load_dirty      = hit_ok && mem_write;
                line_datain_sel = 1'b1;
                dirty_in        = 1'b1;
            end
            write_back: begin
                way_sel_method = 1'b1;  // victim line out
                address_sel    = 1'b1;  // victim tag and index
                pmem_write     = 1'b1;
                if_miss        = 1'b1;
            end
            read_mem: begin
                way_sel_method = 1'b1;  // fill into victim way
                pmem_read      = 1'b1;
                valid_in       = 1'b1;
                if_miss        = 1'b1;
                // dirty_in stays 0, fetched line is clean
                if (pmem_resp) begin
                    load_line_data = 1'b1;
                    load_valid     = 1'b1;  // also writes the tag
                    load_dirty     = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // transitions
    always_comb begin
        next_state = state;
        case (state)
            ready: begin
                if (req && !hit_ok) begin
                    // victim decides whether to flush first
                    next_state = dirty ? write_back : read_mem;
                end
            end
            write_back: begin
                if (pmem_resp)
                    next_state = read_mem;
            end
            read_mem: begin
                if (pmem_resp)
                    next_state = ready;  // retried as a hit
            end
            default: next_state = ready;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= ready;
        else
            state <= next_state;
    end

endmodule

//--- hw/icache_datapath.sv
`timescale 1ns/1ns

module icache_datapath #(
    parameter int sets = 8
) (
    input  logic                         clk,
    input  logic                         arst_n,
    // host side
    input  logic [cache_pkg::addr_w-1:0] mem_address,
    input  cache_pkg::word_t             mem_wdata,
    output cache_pkg::word_t             mem_rdata,
    // physical memory side
    input  cache_pkg::line_t             pmem_rdata,
    output logic [cache_pkg::addr_w-1:0] pmem_address,
    output cache_pkg::line_t             pmem_wdata,
    // from control
    input  logic                         way_sel_method,
    input  logic                         load_line_data,
    input  logic                         load_valid,
    input  logic                         load_dirty,
    input  logic                         load_lru,
    input  logic                         line_datain_sel,
    input  logic                         valid_in,
    input  logic                         dirty_in,
    input  logic                         address_sel,
    // to control
    output logic                         hit,
    output logic                         valid,
    output logic                         dirty
);

    import cache_pkg::*;

    localparam int idx_w  = $clog2(sets);
    localparam int tag_w  = addr_w - idx_w - offset_w;
    localparam int wsel_w = $clog2(line_words);

    // request address fields
    logic [tag_w-1:0]  req_tag;
    logic [idx_w-1:0]  idx;
    logic [wsel_w-1:0] word_idx;

    assign req_tag  = mem_address[addr_w-1 -: tag_w];
    assign idx      = mem_address[offset_w +: idx_w];
    assign word_idx = mem_address[offset_w-1 -: wsel_w];

    // storage, two ways
    logic [tag_w-1:0] tag_arr  [2][sets];  // no reset
    line_t            line_arr [2][sets];  // no reset
    logic [sets-1:0]  valid_q  [2];
    logic [sets-1:0]  dirty_q  [2];
    logic [sets-1:0]  lru_q;               // way to evict next

    logic [1:0] tag_eq;
    logic [1:0] way_match;
    logic       hit_way;
    logic       victim;
    logic       sel_way;
    line_t      sel_line;
    line_t      line_in;

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            tag_eq[w]    = (tag_arr[w][idx] == req_tag);
            way_match[w] = tag_eq[w] && valid_q[w][idx];  // X tag masked by valid
        end
    end

    assign hit     = |tag_eq;
    assign valid   = |way_match;
    assign hit_way = way_match[1];  // way 0 unless way 1 holds it

    assign victim  = lru_q[idx];
    assign sel_way = way_sel_method ? victim : hit_way;
    assign dirty   = dirty_q[victim][idx];

    // read side
    assign sel_line   = line_arr[sel_way][idx];
    assign mem_rdata  = sel_line.words[word_idx];
    assign pmem_wdata = sel_line;  // victim line during write back

    // line going into the array
    always_comb begin
        line_in = sel_line;
        if (line_datain_sel)
            line_in.words[word_idx] = mem_wdata;  // write hit merge
        else
            line_in.flat = pmem_rdata.flat;       // refill
    end

    // line aligned pmem address
    always_comb begin
        if (address_sel)
            pmem_address = {tag_arr[victim][idx], idx, {offset_w{1'b0}}};
        else
            pmem_address = {mem_address[addr_w-1:offset_w], {offset_w{1'b0}}};
    end

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (load_line_data)
            line_arr[sel_way][idx] <= line_in;
        if (load_valid)
            tag_arr[sel_way][idx] <= req_tag;  // only on refill
    end

    // status bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (load_valid)
                valid_q[sel_way][idx] <= valid_in;
            if (load_dirty)
                dirty_q[sel_way][idx] <= dirty_in;
            if (load_lru)
                lru_q[idx] <= ~sel_way;  // point at the other way
        end
    end

endmodule

//--- hw/icache.sv
`timescale 1ns/1ns

module icache #(
    parameter int sets = 8
) (
    input  logic                         clk,
    input  logic                         arst_n,
    // host
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic [cache_pkg::addr_w-1:0] mem_address,
    input  cache_pkg::word_t             mem_wdata,
    output logic                         mem_resp,
    output cache_pkg::word_t             mem_rdata,
    // physical memory
    output logic                         pmem_read,
    output logic                         pmem_write,
    output logic [cache_pkg::addr_w-1:0] pmem_address,
    output cache_pkg::line_t             pmem_wdata,
    input  cache_pkg::line_t             pmem_rdata,
    input  logic                         pmem_resp,
    // miss traffic
    output logic                         if_miss
);

    // control to datapath
    logic way_sel_method;
    logic load_line_data;
    logic load_valid;
    logic load_dirty;
    logic load_lru;
    logic line_datain_sel;
    logic valid_in;
    logic dirty_in;
    logic address_sel;
    // datapath to control
    logic hit;
    logic valid;
    logic dirty;

    icache_control u_control (
        .clk             (clk),
        .arst_n          (arst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_resp        (mem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_resp       (pmem_resp),
        .hit             (hit),
        .valid           (valid),
        .dirty           (dirty),
        .way_sel_method  (way_sel_method),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .address_sel     (address_sel),
        .if_miss         (if_miss)
    );

    icache_datapath #(
        .sets (sets)
    ) u_datapath (
        .clk             (clk),
        .arst_n          (arst_n),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .way_sel_method  (way_sel_method),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .address_sel     (address_sel),
        .hit             (hit),
        .valid           (valid),
        .dirty           (dirty)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int period       = 20,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 arst_n = 1'b1;  // released just after an edge
    end

endmodule

//--- bench/icache_sva.sv
`timescale 1ns/1ns

module icache_sva (
    input logic clk,
    input logic arst_n,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp,
    input logic if_miss
);

    int fails = 0;

    // one pmem direction at a time
    a_pmem_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(pmem_read && pmem_write))
    else begin
        $error("pmem_read and pmem_write are high together");
        fails++;
    end

    // no answer without a request
    a_resp_req: assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp |-> (mem_read || mem_write))
    else begin
        $error("mem_resp is high with no host request");
        fails++;
    end

    a_reset_idle: assert property (@(posedge clk)
        !arst_n |-> (!pmem_read && !pmem_write))
    else begin
        $error("pmem request is active during reset");
        fails++;
    end

    // requests held until pmem_resp
    a_read_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (pmem_read && !pmem_resp) |=> pmem_read)
    else begin
        $error("pmem_read dropped before pmem_resp");
        fails++;
    end

    a_write_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (pmem_write && !pmem_resp) |=> pmem_write)
    else begin
        $error("pmem_write dropped before pmem_resp");
        fails++;
    end

    // miss flag follows pmem traffic, low in reset too
    a_miss_flag: assert property (@(posedge clk)
        if_miss == (pmem_read || pmem_write))
    else begin
        $error("if_miss does not match the pmem miss traffic");
        fails++;
    end

endmodule

bind icache_control icache_sva u_sva (
    .clk        (clk),
    .arst_n     (arst_n),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write),
    .pmem_resp  (pmem_resp),
    .if_miss    (if_miss)
);

//--- bench/icache_checker.sv
`timescale 1ns/1ns

module icache_checker #(
    parameter int          mem_bytes = 1024,
    parameter logic [31:0] init_key  = 32'h0
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic [cache_pkg::addr_w-1:0] mem_address,
    input  cache_pkg::word_t             mem_wdata,
    input  logic                         mem_resp,
    input  cache_pkg::word_t             mem_rdata,
    input  logic                         pmem_write,
    input  logic                         pmem_resp,
    input  logic [cache_pkg::addr_w-1:0] pmem_address,
    input  cache_pkg::line_t             pmem_wdata,
    output int                           errors,
    output int                           resps
);

    import cache_pkg::*;

    localparam int n_words    = mem_bytes / 4;
    localparam int word_idx_w = $clog2(n_words);
    localparam int wsel_w     = $clog2(line_words);
    localparam int line_idx_w = word_idx_w - wsel_w;

    word_t                 model [n_words];  // current value of every word
    logic [word_idx_w-1:0] wi;
    logic [line_idx_w-1:0] li;
    line_t                 exp_line;
    int                    err_cnt  = 0;
    int                    resp_cnt = 0;

    assign errors = err_cnt;
    assign resps  = resp_cnt;

    initial begin
        for (int i = 0; i < n_words; i++)
            model[i] = (i * 4) ^ init_key;  // same fill as the memory model
    end

    // everything sampled mid cycle
    always @(negedge clk) begin
        if (arst_n && mem_resp && (mem_read || mem_write)) begin
            wi = mem_address[2 +: word_idx_w];
            resp_cnt++;
            if (mem_write) begin
                model[wi] = mem_wdata;  // committed at the next edge
            end else if (mem_rdata !== model[wi]) begin
                $display("FAIL %0t mem_rdata @%h expected %h got %h",
                         $time, mem_address, model[wi], mem_rdata);
                err_cnt++;
            end
        end
        if (arst_n && pmem_write && pmem_resp) begin
            if (pmem_address[offset_w-1:0] != '0) begin
                $display("FAIL %0t pmem_address expected %h got %h",
                         $time, {pmem_address[addr_w-1:offset_w], 5'b0}, pmem_address);
                err_cnt++;
            end
            if (pmem_address >= mem_bytes) begin
                $display("write-back to %h lies outside the tested address range", pmem_address);
                err_cnt++;
            end else begin
                li = pmem_address[offset_w +: line_idx_w];
                for (int w = 0; w < line_words; w++)
                    exp_line.words[w] = model[{li, w[wsel_w-1:0]}];
                if (pmem_wdata !== exp_line) begin
                    $display("FAIL %0t pmem_wdata expected %h got %h",
                             $time, exp_line.flat, pmem_wdata.flat);
                    err_cnt++;
                end
            end
        end
    end

endmodule

//--- bench/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;

    import cache_pkg::*;

    localparam int          cache_sets   = 8;
    localparam int          num_requests = 400;
    localparam int          span_bytes   = 4 * cache_sets * 32;  // four lines per set
    localparam int          n_lines      = span_bytes / 32;
    localparam int          line_idx_w   = $clog2(n_lines);
    localparam int          max_cycles   = num_requests * 20;
    localparam logic [31:0] init_key     = 32'h5ca1_ab1e;        // memory fill pattern

    logic              clk;
    logic              arst_n;
    logic              mem_read;
    logic              mem_write;
    logic              mem_resp;
    logic [addr_w-1:0] mem_address;
    word_t             mem_wdata;
    word_t             mem_rdata;
    logic              pmem_read;
    logic              pmem_write;
    logic              pmem_resp;
    logic [addr_w-1:0] pmem_address;
    line_t             pmem_wdata;
    line_t             pmem_rdata;
    logic              if_miss;

    integer seed      = 54619;
    int     done_reqs = 0;
    int     cycles    = 0;
    int     tb_errors = 0;
    int     chk_errors;
    int     chk_resps;

    line_t mem_lines [n_lines];  // physical memory, one entry per line

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    icache #(
        .sets (cache_sets)
    ) dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .if_miss      (if_miss)
    );

    icache_checker #(
        .mem_bytes (span_bytes),
        .init_key  (init_key)
    ) u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .pmem_write   (pmem_write),
        .pmem_resp    (pmem_resp),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .errors       (chk_errors),
        .resps        (chk_resps)
    );

    // closing line, verdict, stop
    task automatic report_and_stop();
        int sva_fails;
        int total;
        sva_fails = dut.u_control.u_sva.fails;
        total     = tb_errors + chk_errors + sva_fails;
        $display("errors checker %0d assertions %0d bench %0d, answered %0d of %0d",
                 chk_errors, sva_fails, tb_errors, chk_resps, num_requests);
        if (total == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    // mem_resp is stable mid cycle
    task automatic await_resp();
        @(negedge clk);
        while (!mem_resp)
            @(negedge clk);
    endtask

    // host driver
    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        for (int n = 0; n < num_requests; n++) begin
            rnd         = $random(seed);
            mem_write   = rnd[0];   // read or write, even odds
            mem_read    = ~rnd[0];
            rnd         = $random(seed);
            addr        = rnd % span_bytes;
            mem_address = {addr[addr_w-1:2], 2'b00};  // word aligned
            mem_wdata   = $random(seed);
            await_resp();
            @(posedge clk);          // accepted at this edge
            #1;
            done_reqs++;
        end
        mem_read  = 1'b0;
        mem_write = 1'b0;
        repeat (2) @(posedge clk);
        if (chk_resps != num_requests) begin
            $display("request count mismatch, checker saw %0d answers, expected %0d",
                     chk_resps, num_requests);
            tb_errors++;
        end
        report_and_stop();
    end

    // physical memory, 2 to 6 cycle latency
    initial begin
        logic [31:0]           rnd;
        int                    lat;
        logic [line_idx_w-1:0] li;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        for (int l = 0; l < n_lines; l++)
            for (int w = 0; w < line_words; w++)
                mem_lines[l].words[w] = (l * 32 + w * 4) ^ init_key;  // byte address based
        @(posedge clk);
        #1;
        forever begin
            if (pmem_read || pmem_write) begin
                rnd = $random(seed);
                lat = 2 + int'(rnd % 5);
                repeat (lat - 1) @(posedge clk);
                #1;
                li = pmem_address[offset_w +: line_idx_w];
                if (pmem_write)
                    mem_lines[li] = pmem_wdata;   // victim stored
                else
                    pmem_rdata = mem_lines[li];
                pmem_resp = 1'b1;                 // one cycle pulse
                @(posedge clk);
                #1;
                pmem_resp = 1'b0;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    end

    // run limit
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d requests were answered",
                 cycles, done_reqs, num_requests);
        tb_errors++;
        report_and_stop();
    end

endmodule

//--- sources.f
hw/cache_pkg.sv
hw/icache_control.sv
hw/icache_datapath.sv
hw/icache.sv
bench/tb_clock.sv
bench/icache_sva.sv
bench/icache_checker.sv
bench/icache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module icache_tb -Mdir obj_dir

out=$(./obj_dir/Vicache_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "NO ERRORS"
